// File: list.f
hdl/soc_pkg.sv
hdl/axi_lite_router.sv
hdl/boot_rom.sv
hdl/clint_timer.sv
hdl/scratch_ram.sv
hdl/soc_fabric.sv
bench/tb_clock_gen.sv
bench/soc_fabric_sva.sv
bench/tb_soc_fabric.sv

// File: bench/tb_soc_fabric.sv
// --------------------------------------------------
// Testbench for the SoC memory fabric
// Table of ROM, RAM and unmapped accesses in a loop
// Directed CLINT, back-pressure and reset checks
// Checker task, per-wait timeouts, closing summary
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_soc_fabric;

    import soc_pkg::*;

    localparam int RAM_WORDS = 1024;
    localparam int TIMEOUT   = 100;

    // Signals a wait can watch
    localparam int F_AW_READY = 0;
    localparam int F_AR_READY = 1;
    localparam int F_B_VALID  = 2;
    localparam int F_R_VALID  = 3;
    localparam int F_IPI      = 4;
    localparam int F_TIMER    = 5;

    // One table entry
    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [63:0] wdata;
        logic [7:0]  wstrb;
        logic [63:0] exp_data;
        logic [1:0]  exp_resp;
        logic        chk_data;
    } vec_t;

    logic        clk;
    logic        reset;
    axil_req_t   req;
    axil_resp_t  resp;
    logic        timer_irq;
    logic        ipi;

    vec_t        vec_q [$];
    logic [63:0] ram_model [RAM_WORDS];
    int          n_tests  = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          err_mark = 0;

    tb_clock_gen #(.PERIOD_NS(4.0)) u_clk (.clk_o(clk));

    soc_fabric #(
        .RAM_WORDS ( RAM_WORDS )
    ) DUT (
        .clk_i       ( clk       ),
        .reset_i     ( reset     ),
        .req_i       ( req       ),
        .resp_o      ( resp      ),
        .timer_irq_o ( timer_irq ),
        .ipi_o       ( ipi       )
    );

    bind axi_lite_router soc_fabric_sva u_sva (
        .clk_i   ( clk_i   ),
        .reset_i ( reset_i ),
        .req_i   ( req_i   ),
        .resp_i  ( resp_o  )
    );

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] ram_addr(input int idx);
        return {RAM_REGION, 24'(idx * 8)};
    endfunction

    // Byte lanes of new data over old
    function automatic logic [63:0] merge_bytes(input logic [63:0] old_w,
                                                input logic [63:0] new_w,
                                                input logic [7:0]  strb);
        logic [63:0] res;
        res = old_w;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic flag_value(input int which);
        case (which)
            F_AW_READY: return resp.aw_ready;
            F_AR_READY: return resp.ar_ready;
            F_B_VALID:  return resp.b_valid;
            F_R_VALID:  return resp.r_valid;
            F_IPI:      return ipi;
            default:    return timer_irq;
        endcase
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        n_checks++;
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            n_errors++;
        end
    endtask

    // Sampled mid-cycle, bounded by TIMEOUT
    task automatic wait_flag(input int which, input logic level, input string what);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (flag_value(which) !== level && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (flag_value(which) !== level) begin
            $display("timeout: %s never went to %0b within %0d cycles", what, level, TIMEOUT);
            n_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        $display("test %0d %s %s", n_tests, name, (n_errors == err_mark) ? "ok" : "mismatch");
        err_mark = n_errors;
    endtask

    // --------------------------------------------------
    // Bus transactions
    // --------------------------------------------------
    task automatic do_write(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb, input int delay,
                            output logic [1:0] bresp);
        @(posedge clk);
        req.aw_valid <= 1'b1;
        req.aw_addr  <= addr;
        req.w_valid  <= 1'b1;
        req.w_data   <= data;
        req.w_strb   <= strb;
        wait_flag(F_AW_READY, 1'b1, "aw_ready");
        @(posedge clk);
        req.aw_valid <= 1'b0;
        req.w_valid  <= 1'b0;
        wait_flag(F_B_VALID, 1'b1, "b_valid");
        bresp = resp.b_resp;
        // Stalled master, response must hold
        for (int i = 0; i < delay; i++) begin
            @(negedge clk);
            check(resp.b_valid, 1'b1, "b_valid dropped under back-pressure");
            check(resp.b_resp, bresp, "b_resp changed under back-pressure");
        end
        @(posedge clk);
        req.b_ready <= 1'b1;
        @(posedge clk);
        req.b_ready <= 1'b0;
    endtask

    task automatic start_read(input logic [31:0] addr);
        @(posedge clk);
        req.ar_valid <= 1'b1;
        req.ar_addr  <= addr;
        wait_flag(F_AR_READY, 1'b1, "ar_ready");
    endtask

    // Next address may be left queued on the AR channel
    task automatic collect_read(input int delay, input logic queue_next,
                                input logic [31:0] next_addr,
                                output logic [63:0] rdata, output logic [1:0] rresp);
        @(posedge clk);
        req.ar_valid <= queue_next;
        req.ar_addr  <= next_addr;
        wait_flag(F_R_VALID, 1'b1, "r_valid");
        rdata = resp.r_data;
        rresp = resp.r_resp;
        for (int i = 0; i < delay; i++) begin
            @(negedge clk);
            check(resp.r_valid, 1'b1, "r_valid dropped under back-pressure");
            check(resp.r_data, rdata, "r_data changed under back-pressure");
            check(resp.ar_ready, 1'b0, "ar_ready raised while a read response waits");
        end
        @(posedge clk);
        req.r_ready <= 1'b1;
        @(posedge clk);
        req.r_ready <= 1'b0;
    endtask

    task automatic do_read(input logic [31:0] addr, input int delay,
                           output logic [63:0] rdata, output logic [1:0] rresp);
        start_read(addr);
        collect_read(delay, 1'b0, 32'h0, rdata, rresp);
    endtask

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------
    function automatic void add_vec(input logic wr, input logic [31:0] addr,
                                    input logic [63:0] wdata, input logic [7:0] wstrb,
                                    input logic [63:0] exp_data, input logic [1:0] exp_resp,
                                    input logic chk_data);
        vec_t v;
        v.wr       = wr;
        v.addr     = addr;
        v.wdata    = wdata;
        v.wstrb    = wstrb;
        v.exp_data = exp_data;
        v.exp_resp = exp_resp;
        v.chk_data = chk_data;
        vec_q.push_back(v);
    endfunction

    task automatic build_table();
        int          idx [4];
        logic [63:0] data;
        // Boot image, then the first word past it
        for (int i = 0; i < ROM_WORDS; i++) begin
            add_vec(1'b0, {ROM_REGION, 24'(i * 8)}, '0, '0, rom_image[i], RESP_OKAY, 1'b1);
        end
        add_vec(1'b0, {ROM_REGION, 24'(ROM_WORDS * 8)}, '0, '0, '0, RESP_OKAY, 1'b1);
        add_vec(1'b1, {ROM_REGION, 24'h000010}, 64'h0123_4567_89ab_cdef, 8'hff, '0,
                RESP_SLVERR, 1'b0);
        // Full-word RAM writes, then read back
        for (int i = 0; i < 4; i++) begin
            idx[i] = $urandom_range(RAM_WORDS - 1);
            data   = {$urandom, $urandom};
            ram_model[idx[i]] = data;
            add_vec(1'b1, ram_addr(idx[i]), data, 8'hff, '0, RESP_OKAY, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            add_vec(1'b0, ram_addr(idx[i]), '0, '0, ram_model[idx[i]], RESP_OKAY, 1'b1);
        end
        // Partial strobe merges into the first word
        data = {$urandom, $urandom};
        ram_model[idx[0]] = merge_bytes(ram_model[idx[0]], data, 8'h5a);
        add_vec(1'b1, ram_addr(idx[0]), data, 8'h5a, '0, RESP_OKAY, 1'b0);
        add_vec(1'b0, ram_addr(idx[0]), '0, '0, ram_model[idx[0]], RESP_OKAY, 1'b1);
        // Unmapped region
        add_vec(1'b0, 32'h4000_0100, '0, '0, '0, RESP_DECERR, 1'b1);
        add_vec(1'b1, 32'h4000_0200, 64'hffff_0000_ffff_0000, 8'hff, '0, RESP_DECERR, 1'b0);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        vec_t        v;
        logic [63:0] rdata;
        logic [63:0] first;
        logic [1:0]  rsp;
        int          idx_a;
        int          idx_b;
        void'($urandom(32'h94fe));
        reset = 1'b1;
        req   = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // Quiet outputs straight out of reset
        @(negedge clk);
        check(resp.aw_ready, 1'b0, "aw_ready after reset");
        check(resp.w_ready, 1'b0, "w_ready after reset");
        check(resp.ar_ready, 1'b0, "ar_ready after reset");
        check(resp.b_valid, 1'b0, "b_valid after reset");
        check(resp.r_valid, 1'b0, "r_valid after reset");
        check(timer_irq, 1'b0, "timer_irq_o after reset");
        check(ipi, 1'b0, "ipi_o after reset");
        finish_test("reset state");

        build_table();
        foreach (vec_q[i]) begin
            v = vec_q[i];
            if (v.wr) begin
                do_write(v.addr, v.wdata, v.wstrb, 0, rsp);
            end else begin
                do_read(v.addr, 0, rdata, rsp);
                if (v.chk_data) begin
                    check(rdata, v.exp_data, $sformatf("read data at %h", v.addr));
                end
            end
            check(rsp, v.exp_resp, $sformatf("response at %h", v.addr));
            finish_test($sformatf("%s %h", v.wr ? "write" : "read", v.addr));
        end

        // Software interrupt follows msip bit 0
        do_write({CLINT_REGION, MSIP_OFFSET}, 64'h1, 8'hff, 0, rsp);
        check(rsp, RESP_OKAY, "msip set response");
        wait_flag(F_IPI, 1'b1, "ipi_o");
        do_write({CLINT_REGION, MSIP_OFFSET}, 64'h0, 8'hff, 0, rsp);
        wait_flag(F_IPI, 1'b0, "ipi_o");
        finish_test("clint msip");

        // Compare at zero fires, all ones clears
        do_write({CLINT_REGION, MTIMECMP_OFFSET}, 64'h0, 8'hff, 0, rsp);
        check(rsp, RESP_OKAY, "mtimecmp write response");
        wait_flag(F_TIMER, 1'b1, "timer_irq_o");
        do_write({CLINT_REGION, MTIMECMP_OFFSET}, '1, 8'hff, 0, rsp);
        wait_flag(F_TIMER, 1'b0, "timer_irq_o");
        finish_test("clint mtimecmp");

        // mtime only moves forward
        do_read({CLINT_REGION, MTIME_OFFSET}, 0, first, rsp);
        check(rsp, RESP_OKAY, "mtime read response");
        do_read({CLINT_REGION, MTIME_OFFSET}, 0, rdata, rsp);
        check(rdata > first, 1'b1, "mtime did not increase");
        first = rdata;
        do_write({CLINT_REGION, MTIME_OFFSET}, 64'h0, 8'hff, 0, rsp);
        do_read({CLINT_REGION, MTIME_OFFSET}, 0, rdata, rsp);
        check(rdata > first, 1'b1, "mtime went back after a write");
        finish_test("clint mtime");

        // Stalled write response
        idx_a = $urandom_range(RAM_WORDS - 1);
        idx_b = (idx_a + 1) % RAM_WORDS;
        ram_model[idx_a] = {$urandom, $urandom};
        ram_model[idx_b] = {$urandom, $urandom};
        do_write(ram_addr(idx_a), ram_model[idx_a], 8'hff, $urandom_range(10, 1), rsp);
        check(rsp, RESP_OKAY, "stalled write response");
        do_write(ram_addr(idx_b), ram_model[idx_b], 8'hff, 0, rsp);
        finish_test("b_ready back-pressure");

        // Stalled read with a second read queued behind it
        start_read(ram_addr(idx_a));
        collect_read($urandom_range(10, 1), 1'b1, ram_addr(idx_b), rdata, rsp);
        check(rdata, ram_model[idx_a], "stalled read data");
        check(rsp, RESP_OKAY, "stalled read response");
        wait_flag(F_AR_READY, 1'b1, "queued ar_ready");
        collect_read(0, 1'b0, 32'h0, rdata, rsp);
        check(rdata, ram_model[idx_b], "queued read data");
        check(rsp, RESP_OKAY, "queued read response");
        finish_test("r_ready back-pressure, queued read");

        // Bound protocol assertions count as errors too
        n_errors += DUT.u_router.u_sva.n_fail;

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/soc_fabric_sva.sv
// --------------------------------------------------
// Protocol assertions for the AXI4-Lite router
// Response hold, busy back-pressure, paired write ready
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module soc_fabric_sva (
    input wire logic                clk_i,
    input wire logic                reset_i,
    input wire soc_pkg::axil_req_t  req_i,
    input wire soc_pkg::axil_resp_t resp_i
);

    // Failed assertion count
    int n_fail = 0;

    // Write response held until the master takes it
    a_b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        resp_i.b_valid && !req_i.b_ready |=> resp_i.b_valid)
        else begin
            $error("b_valid dropped before b_ready");
            n_fail++;
        end

    // Read response and its data held until taken
    a_r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        resp_i.r_valid && !req_i.r_ready |=> resp_i.r_valid && $stable(resp_i.r_data))
        else begin
            $error("r_valid or r_data changed before r_ready");
            n_fail++;
        end

    // Busy while a response waits
    a_no_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        (resp_i.b_valid || resp_i.r_valid)
            |-> !(resp_i.aw_ready || resp_i.w_ready || resp_i.ar_ready))
        else begin
            $error("ready raised while a response is pending");
            n_fail++;
        end

    // Address and data accepted as a pair, answered next cycle
    a_aw_w_pair: assert property (@(posedge clk_i) disable iff (reset_i)
        (resp_i.aw_ready || resp_i.w_ready)
            |-> (resp_i.aw_ready && resp_i.w_ready && req_i.aw_valid && req_i.w_valid)
                ##1 resp_i.b_valid)
        else begin
            $error("write readies not paired with both valids and a response");
            n_fail++;
        end

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
// --------------------------------------------------
// Testbench clock source
// Free-running square wave, 50 % duty
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk_o
);

    // Half period per edge
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// File: hdl/soc_fabric.sv
// --------------------------------------------------
// SoC memory fabric top level
// AXI4-Lite router with boot ROM, CLINT and RAM
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module soc_fabric #(
    parameter int RAM_WORDS = 1024
) (
    input  wire logic               clk_i,
    input  wire logic               reset_i,
    input  wire soc_pkg::axil_req_t req_i,
    output soc_pkg::axil_resp_t     resp_o,
    output logic                    timer_irq_o,
    output logic                    ipi_o
);

    import soc_pkg::*;

    // Shared target request and per-target valids
    tgt_req_t          tgt_req;
    logic              rom_valid;
    logic              clint_valid;
    logic              ram_valid;

    // Registered read data back to the router
    logic [DATA_W-1:0] rom_rdata;
    logic [DATA_W-1:0] clint_rdata;
    logic [DATA_W-1:0] ram_rdata;

    // --------------------------------------------------
    // Router
    // --------------------------------------------------
    axi_lite_router u_router (
        .clk_i         ( clk_i       ),
        .reset_i       ( reset_i     ),
        .req_i         ( req_i       ),
        .resp_o        ( resp_o      ),
        .tgt_req_o     ( tgt_req     ),
        .rom_valid_o   ( rom_valid   ),
        .clint_valid_o ( clint_valid ),
        .ram_valid_o   ( ram_valid   ),
        .rom_rdata_i   ( rom_rdata   ),
        .clint_rdata_i ( clint_rdata ),
        .ram_rdata_i   ( ram_rdata   )
    );

    // --------------------------------------------------
    // Targets
    // --------------------------------------------------
    boot_rom u_rom (
        .clk_i    ( clk_i          ),
        .valid_i  ( rom_valid      ),
        .offset_i ( tgt_req.offset ),
        .rdata_o  ( rom_rdata      )
    );

    clint_timer u_clint (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .valid_i     ( clint_valid ),
        .req_i       ( tgt_req     ),
        .rdata_o     ( clint_rdata ),
        .timer_irq_o ( timer_irq_o ),
        .ipi_o       ( ipi_o       )
    );

    scratch_ram #(
        .RAM_WORDS ( RAM_WORDS )
    ) u_ram (
        .clk_i   ( clk_i     ),
        .valid_i ( ram_valid ),
        .req_i   ( tgt_req   ),
        .rdata_o ( ram_rdata )
    );

endmodule

`default_nettype wire

// File: hdl/scratch_ram.sv
// --------------------------------------------------
// Scratch RAM in place of the DRAM path
// Byte-strobed writes, registered reads
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module scratch_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  wire logic                  clk_i,
    input  wire logic                  valid_i,
    input  wire soc_pkg::tgt_req_t     req_i,
    output logic [soc_pkg::DATA_W-1:0] rdata_o
);

    import soc_pkg::*;

    // Index width and byte lane bits
    localparam int IDX_W    = $clog2(RAM_WORDS);
    localparam int WORD_LSB = $clog2(STRB_W);

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0]  idx;
    logic [DATA_W-1:0] rdata_q;

    // Upper offset bits alias, the region wraps
    assign idx = req_i.offset[WORD_LSB +: IDX_W];

    // Write lands on the request edge
    always_ff @(posedge clk_i) begin
        if (valid_i && req_i.write) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (req_i.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // Read data held until the next read
    always_ff @(posedge clk_i) begin
        if (valid_i && !req_i.write) begin
            rdata_q <= mem[idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hdl/clint_timer.sv
// --------------------------------------------------
// Core-local interruptor for a single hart
// Free-running mtime, mtimecmp and msip registers
// Registered timer and software interrupt outputs
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module clint_timer (
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire logic                  valid_i,
    input  wire soc_pkg::tgt_req_t     req_i,
    output logic [soc_pkg::DATA_W-1:0] rdata_o,
    output logic                       timer_irq_o,
    output logic                       ipi_o
);

    import soc_pkg::*;

    logic [DATA_W-1:0]   mtime_q;
    logic [DATA_W-1:0]   mtimecmp_q;
    logic                msip_q;
    logic                timer_irq_q;
    logic                ipi_q;
    logic [DATA_W-1:0]   rdata_q;
    logic [OFFSET_W-1:0] word_off;
    logic                wr_en;
    logic                rd_en;
    logic                sel_msip;
    logic                sel_cmp;
    logic                sel_mtime;

    // --------------------------------------------------
    // Register decode
    // --------------------------------------------------
    // Drop the byte lane bits
    assign word_off = req_i.offset & ~(OFFSET_W'(STRB_W - 1));

    assign wr_en = valid_i && req_i.write;
    assign rd_en = valid_i && !req_i.write;

    assign sel_msip  = (word_off == MSIP_OFFSET);
    assign sel_cmp   = (word_off == MTIMECMP_OFFSET);
    assign sel_mtime = (word_off == MTIME_OFFSET);

    // --------------------------------------------------
    // Timer state and interrupts
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtime_q     <= '0;
            // Compare value parked at the top so no early irq
            mtimecmp_q  <= '1;
            msip_q      <= 1'b0;
            timer_irq_q <= 1'b0;
            ipi_q       <= 1'b0;
        end else begin
            // RTC is the system clock
            mtime_q     <= mtime_q + 1'b1;
            timer_irq_q <= (mtime_q >= mtimecmp_q);
            ipi_q       <= msip_q;
            // Only bit 0 of msip is implemented
            if (wr_en && sel_msip && req_i.wstrb[0]) begin
                msip_q <= req_i.wdata[0];
            end
            // Byte lanes of mtimecmp
            if (wr_en && sel_cmp) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (req_i.wstrb[b]) begin
                        mtimecmp_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // Read port, mtime is read-only
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            if (sel_msip) begin
                rdata_q <= {{(DATA_W-1){1'b0}}, msip_q};
            end else if (sel_cmp) begin
                rdata_q <= mtimecmp_q;
            end else if (sel_mtime) begin
                rdata_q <= mtime_q;
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign rdata_o     = rdata_q;
    assign timer_irq_o = timer_irq_q;
    assign ipi_o       = ipi_q;

endmodule

`default_nettype wire

// File: hdl/boot_rom.sv
// --------------------------------------------------
// Boot ROM holding the package boot image
// Registered read, zero beyond the image
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module boot_rom (
    input  wire logic                         clk_i,
    input  wire logic                         valid_i,
    input  wire logic [soc_pkg::OFFSET_W-1:0] offset_i,
    output logic [soc_pkg::DATA_W-1:0]        rdata_o
);

    import soc_pkg::*;

    // Word index bits into the image
    localparam int ROM_AW   = $clog2(ROM_WORDS);
    localparam int WORD_LSB = $clog2(STRB_W);

    logic [OFFSET_W-WORD_LSB-1:0] word_idx;
    logic                         in_image;
    logic [DATA_W-1:0]            rdata_q;

    // Byte offset to word index
    assign word_idx = offset_i[OFFSET_W-1:WORD_LSB];

    // Anything past the last word reads as zero
    assign in_image = (word_idx < ROM_WORDS);

    // Every request here is a read
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            if (in_image) begin
                rdata_q <= rom_image[word_idx[ROM_AW-1:0]];
            end else begin
                rdata_q <= '0;
            end
        end
    end

    // Held until the next request
    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hdl/axi_lite_router.sv
// --------------------------------------------------
// AXI4-Lite router for the memory fabric
// One transaction at a time, idle / wresp / rresp FSM
// Region decode, target valids and response codes
// Read data mux on the registered target select
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module axi_lite_router (
    input  wire logic                       clk_i,
    input  wire logic                       reset_i,
    input  wire soc_pkg::axil_req_t         req_i,
    output soc_pkg::axil_resp_t             resp_o,
    output soc_pkg::tgt_req_t               tgt_req_o,
    output logic                            rom_valid_o,
    output logic                            clint_valid_o,
    output logic                            ram_valid_o,
    input  wire logic [soc_pkg::DATA_W-1:0] rom_rdata_i,
    input  wire logic [soc_pkg::DATA_W-1:0] clint_rdata_i,
    input  wire logic [soc_pkg::DATA_W-1:0] ram_rdata_i
);

    import soc_pkg::*;

    // FSM states
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_WRESP = 2'd1;
    localparam logic [1:0] ST_RRESP = 2'd2;

    // Target select for the read data mux
    localparam logic [1:0] SEL_NONE  = 2'd0;
    localparam logic [1:0] SEL_ROM   = 2'd1;
    localparam logic [1:0] SEL_CLINT = 2'd2;
    localparam logic [1:0] SEL_RAM   = 2'd3;

    logic [1:0] state_q;
    logic [1:0] state_d;
    logic [1:0] sel_q;
    logic [1:0] sel_d;
    logic [1:0] resp_q;
    logic [1:0] resp_d;
    logic       wr_pend;
    logic       wr_hs;
    logic       rd_hs;
    logic       hit_rom;
    logic       hit_clint;
    logic       hit_ram;
    soc_addr_u  addr;

    // --------------------------------------------------
    // Handshake and decode
    // --------------------------------------------------
    // Write needs both channels, and wins over a read
    assign wr_pend = req_i.aw_valid && req_i.w_valid;
    assign wr_hs   = (state_q == ST_IDLE) && wr_pend;
    assign rd_hs   = (state_q == ST_IDLE) && req_i.ar_valid && !wr_pend;

    // Address of whichever channel is being served
    assign addr.raw = wr_pend ? req_i.aw_addr : req_i.ar_addr;

    assign hit_rom   = (addr.fields.region == ROM_REGION);
    assign hit_clint = (addr.fields.region == CLINT_REGION);
    assign hit_ram   = (addr.fields.region == RAM_REGION);

    always_comb begin
        sel_d  = SEL_NONE;
        resp_d = RESP_OKAY;
        if (hit_rom) begin
            sel_d = SEL_ROM;
            // Boot image is read-only
            if (wr_pend) begin
                resp_d = RESP_SLVERR;
            end
        end else if (hit_clint) begin
            sel_d = SEL_CLINT;
        end else if (hit_ram) begin
            sel_d = SEL_RAM;
        end else begin
            resp_d = RESP_DECERR;
        end
    end

    // One shared request, a valid per target
    assign tgt_req_o.write  = wr_pend;
    assign tgt_req_o.offset = addr.fields.offset;
    assign tgt_req_o.wdata  = req_i.w_data;
    assign tgt_req_o.wstrb  = req_i.w_strb;

    assign rom_valid_o   = rd_hs && hit_rom;
    assign clint_valid_o = (wr_hs || rd_hs) && hit_clint;
    assign ram_valid_o   = (wr_hs || rd_hs) && hit_ram;

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (wr_hs) begin
                    state_d = ST_WRESP;
                end else if (rd_hs) begin
                    state_d = ST_RRESP;
                end
            end
            // Hold the response until the master takes it
            ST_WRESP: begin
                if (req_i.b_ready) begin
                    state_d = ST_IDLE;
                end
            end
            ST_RRESP: begin
                if (req_i.r_ready) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            sel_q   <= SEL_NONE;
            resp_q  <= RESP_OKAY;
        end else begin
            state_q <= state_d;
            // Capture target and code at the handshake
            if (wr_hs || rd_hs) begin
                sel_q  <= sel_d;
                resp_q <= resp_d;
            end
        end
    end

    // --------------------------------------------------
    // Response channels
    // --------------------------------------------------
    always_comb begin
        resp_o.aw_ready = wr_hs;
        resp_o.w_ready  = wr_hs;
        resp_o.ar_ready = rd_hs;
        resp_o.b_valid  = (state_q == ST_WRESP);
        resp_o.b_resp   = resp_q;
        resp_o.r_valid  = (state_q == ST_RRESP);
        resp_o.r_resp   = resp_q;
        // Zero data on a decode error
        case (sel_q)
            SEL_ROM:   resp_o.r_data = rom_rdata_i;
            SEL_CLINT: resp_o.r_data = clint_rdata_i;
            SEL_RAM:   resp_o.r_data = ram_rdata_i;
            default:   resp_o.r_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/soc_pkg.sv
// --------------------------------------------------
// Shared definitions for the SoC memory fabric
// Bus widths and the region address map
// CLINT register offsets and AXI response codes
// Address union, bus structs and boot ROM image
// --------------------------------------------------
`default_nettype none

package soc_pkg;

    // Bus geometry
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 64;
    localparam int STRB_W   = DATA_W / 8;
    localparam int REGION_W = 8;
    localparam int OFFSET_W = ADDR_W - REGION_W;

    // --------------------------------------------------
    // Address map
    // --------------------------------------------------
    localparam logic [REGION_W-1:0] ROM_REGION   = 8'h01;
    localparam logic [REGION_W-1:0] CLINT_REGION = 8'h02;
    localparam logic [REGION_W-1:0] RAM_REGION   = 8'h80;

    // CLINT register offsets, single hart
    localparam logic [OFFSET_W-1:0] MSIP_OFFSET     = 24'h000000;
    localparam logic [OFFSET_W-1:0] MTIMECMP_OFFSET = 24'h004000;
    localparam logic [OFFSET_W-1:0] MTIME_OFFSET    = 24'h00BFF8;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // --------------------------------------------------
    // Boot image
    // --------------------------------------------------
    localparam int ROM_WORDS = 8;

    // Two instructions per word, lower one first
    // Loads the jump target from word 3 and branches to RAM
    localparam logic [DATA_W-1:0] rom_image [ROM_WORDS] = '{
        64'h02028593_00000297,  // auipc t0 / addi a1
        64'h0182b283_f1402573,  // csrr mhartid / ld t0,24(t0)
        64'h00000013_00028067,  // jr t0 / nop
        64'h00000000_80000000,  // RAM base as jump target
        64'hffdff06f_10500073,  // wfi / j back to wfi
        64'h00000013_00000013,
        64'h00000013_00000013,
        64'h00000013_00000013
    };

    // Same 32 bits seen whole or split into region and offset
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [REGION_W-1:0] region;
            logic [OFFSET_W-1:0] offset;
        } fields;
    } soc_addr_u;

    // Master to fabric
    typedef struct packed {
        logic              aw_valid;
        logic [ADDR_W-1:0] aw_addr;
        logic              w_valid;
        logic [DATA_W-1:0] w_data;
        logic [STRB_W-1:0] w_strb;
        logic              b_ready;
        logic              ar_valid;
        logic [ADDR_W-1:0] ar_addr;
        logic              r_ready;
    } axil_req_t;

    // Fabric to master
    typedef struct packed {
        logic              aw_ready;
        logic              w_ready;
        logic              b_valid;
        logic [1:0]        b_resp;
        logic              ar_ready;
        logic              r_valid;
        logic [DATA_W-1:0] r_data;
        logic [1:0]        r_resp;
    } axil_resp_t;

    // Shared request to the targets
    typedef struct packed {
        logic                write;
        logic [OFFSET_W-1:0] offset;
        logic [DATA_W-1:0]   wdata;
        logic [STRB_W-1:0]   wstrb;
    } tgt_req_t;

endpackage

`default_nettype wire
